//--- rv32_wb.f
+incdir+hw
hw/rv32i_types_pkg.sv
hw/mem_access_pkg.sv
hw/load_unit.sv
hw/result_select.sv
hw/mem_wb.sv
hw/writeback_unit.sv
hw/mem_wb_top.sv
tb/mem_wb_sva.sv
tb/mem_wb_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= mem_wb_tb
FILELIST  ?= rv32_wb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/mem_wb_tb.sv
`timescale 1ns/1ps
`include "rv32_wb_config.svh"

module mem_wb_tb
    import rv32i_types_pkg::*;
    import mem_access_pkg::*;
();

    typedef struct packed {
        logic                   is_mem;
        logic                   is_store;
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic [`MEM_ADDR_W-1:0] idx;
        logic [31:0]            acc_cyc;
    } exp_t;

    localparam int mem_words = 1 << `MEM_ADDR_W;
    localparam int total_ops = 40 + 30 + 30 + 20 + 40;
    localparam wb_sel_e nonmem_sel [4] = '{wb_alu, wb_uimm, wb_pc4, wb_br};
    localparam opcode_e nonmem_op [4] = '{op_reg, op_lui, op_jal, op_reg};
    localparam mem_width_e width_tab [5] = '{mw_byte, mw_half, mw_word, mw_byte_u, mw_half_u};

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   ex_valid_i;
    ex_mem_t                ex_bundle_i;
    logic                   mem_ack_i;
    logic [`XLEN-1:0]       mem_rdata_i;
    logic                   ex_ready_o;
    logic                   mem_req_o;
    mem_req_t               mem_cmd_o;
    logic                   wb_valid_o;
    logic                   wb_we_o;
    logic [`REG_ADDR_W-1:0] wb_rd_o;
    logic [`XLEN-1:0]       wb_data_o;

    logic [`XLEN-1:0] mem [mem_words];     // responder memory.
    logic [`XLEN-1:0] ref_mem [mem_words]; // model copy.
    exp_t             exp_q [$];
    integer           seed;
    int               errors = 0;
    int               issued = 0;
    int               retired = 0;
    int               cyc = 0;
    logic             mem_pending;

    mem_wb_top i_mem_wb_top (.*);

    bind mem_wb_top mem_wb_sva i_mem_wb_sva (
        .clk        (clk),
        .rst        (rst),
        .ex_ready_o (ex_ready_o),
        .mem_req_o  (mem_req_o),
        .mem_ack_i  (mem_ack_i),
        .mem_cmd_o  (mem_cmd_o),
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_rd_o    (wb_rd_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
                         input string msg);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    function automatic logic [`XLEN-1:0] fill_word(input int i);
        return (i + 1) * 32'h9e37_79b9;
    endfunction

    function automatic ex_mem_t make_bundle(input int kind);
        ex_mem_t     b;
        logic [31:0] r;
        int          mode;
        r            = $random(seed);
        mode         = (kind >= 3) ? $unsigned(r) % 3 : kind; // 3 and 4 mix the others.
        b            = '0;
        b.rd         = r[8:4];
        b.br_en      = r[9];
        b.pc_plus4   = $random(seed);
        b.alu_out    = $random(seed);
        b.u_imm      = $random(seed) & 32'hffff_f000;
        b.store_data = $random(seed);
        case (mode)
            0: begin
                b.ctrl.reg_write = 1'b1;
                b.ctrl.wb_sel    = nonmem_sel[r[11:10]];
                b.ctrl.opcode    = nonmem_op[r[11:10]];
                b.ctrl.funct3    = (r[11:10] == 2'd3) ? 3'b010 : 3'b000; // slt.
            end
            1: begin
                b.ctrl.opcode    = op_store;
                b.ctrl.mem_write = 1'b1;
                b.ctrl.funct3    = width_tab[$unsigned(r[15:12]) % 3];
            end
            default: begin
                b.ctrl.opcode    = op_load;
                b.ctrl.mem_read  = 1'b1;
                b.ctrl.reg_write = 1'b1;
                b.ctrl.wb_sel    = wb_mem;
                b.ctrl.funct3    = width_tab[$unsigned(r[15:12]) % 5];
            end
        endcase
        // halfwords and words stay aligned.
        if (mode != 0 && b.ctrl.funct3[1:0] == 2'b01) b.alu_out[0] = 1'b0;
        if (mode != 0 && b.ctrl.funct3[1:0] == 2'b10) b.alu_out[1:0] = 2'b00;
        if (kind == 3) b.rd = '0;
        return b;
    endfunction

    // expected write, and the byte merge into the model memory.
    function automatic exp_t model(input ex_mem_t b);
        exp_t             e;
        logic [`XLEN-1:0] w;
        int               sh;
        e          = '0;
        e.rd       = b.rd;
        e.idx      = b.alu_out[`MEM_ADDR_W+1:2];
        e.is_mem   = b.ctrl.mem_read | b.ctrl.mem_write;
        e.is_store = b.ctrl.mem_write;
        e.we       = b.ctrl.reg_write && (b.rd != 0);
        w          = ref_mem[e.idx];
        sh         = 8 * b.alu_out[1:0];
        if (b.ctrl.mem_write) begin
            case (b.ctrl.funct3[1:0])
                2'b00:   w[sh +: 8] = b.store_data[7:0];
                2'b01:   w[sh +: 16] = b.store_data[15:0];
                default: w = b.store_data;
            endcase
            ref_mem[e.idx] = w;
        end else if (b.ctrl.mem_read) begin
            case (b.ctrl.funct3)
                3'b000:  e.data = {{24{w[sh+7]}}, w[sh +: 8]};
                3'b001:  e.data = {{16{w[sh+15]}}, w[sh +: 16]};
                3'b100:  e.data = {24'b0, w[sh +: 8]};
                3'b101:  e.data = {16'b0, w[sh +: 16]};
                default: e.data = w;
            endcase
        end else begin
            case (b.ctrl.wb_sel)
                wb_uimm: e.data = b.u_imm;
                wb_pc4:  e.data = b.pc_plus4;
                wb_br:   e.data = {31'b0, b.br_en};
                default: e.data = b.alu_out;
            endcase
        end
        return e;
    endfunction

    // holds the bundle until the accept edge.
    task automatic issue(input ex_mem_t b);
        exp_t e;
        ex_bundle_i = b;
        ex_valid_i  = 1'b1;
        @(negedge clk);
        while (!ex_ready_o) @(negedge clk);
        @(posedge clk);
        #2;
        ex_valid_i  = 1'b0;
        e           = model(b);
        e.acc_cyc   = cyc;
        mem_pending = e.is_mem;
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic run_test(input string name, input int kind, input int n);
        int err_before;
        int gap;
        err_before = errors;
        for (int k = 0; k < n; k++) begin
            gap = (kind == 4) ? $unsigned($random(seed)) % 3 : 0;
            if (gap != 0) begin
                repeat (gap) @(posedge clk);
                #2;
            end
            issue(make_bundle(kind));
        end
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #2;
        $display("test %s: %0d ops, %0d errors", name, n, errors - err_before);
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check(`XLEN'(wb_valid_o), 0, "wb_valid_o after reset");
        check(`XLEN'(wb_we_o), 0, "wb_we_o after reset");
        check(`XLEN'(mem_req_o), 0, "mem_req_o after reset");
        check(`XLEN'(ex_ready_o), 1, "ex_ready_o after reset");
        @(posedge clk);
        #2;
    endtask

    // data memory, acks after 0 to 3 idle cycles.
    initial begin
        logic [`MEM_ADDR_W-1:0] a;
        int                     delay;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        for (int i = 0; i < mem_words; i++) mem[i] = fill_word(i);
        forever begin
            @(negedge clk);
            if (!rst && mem_req_o && !mem_ack_i) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #2;
                a = mem_cmd_o.addr[`MEM_ADDR_W-1:0];
                for (int i = 0; i < 4; i++) begin
                    if (mem_cmd_o.write && mem_cmd_o.mask[i]) begin
                        mem[a][8*i +: 8] = mem_cmd_o.wdata[8*i +: 8];
                    end
                end
                mem_rdata_i = mem[a];
                mem_ack_i   = 1'b1;
                @(negedge clk);
                while (mem_req_o) @(negedge clk);
                @(posedge clk);
                #2;
                mem_ack_i = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        exp_t e;
        if (!rst && wb_valid_o) begin
            retired++; // every writeback pulse, expected or not.
            if (exp_q.size() == 0) begin
                errors++;
                $display("error at %0t: writeback seen with no bundle pending", $time);
            end else begin
                e = exp_q.pop_front();
                check(`XLEN'(wb_we_o), `XLEN'(e.we), "wb_we_o");
                check(`XLEN'(wb_rd_o), `XLEN'(e.rd), "wb_rd_o");
                if (e.we) check(wb_data_o, e.data, "wb_data_o");
                if (e.is_store) check(mem[e.idx], ref_mem[e.idx], "memory word after store");
                if (!e.is_mem) check(cyc, e.acc_cyc, "non-memory write one cycle after accept");
                if (e.is_mem) mem_pending = 1'b0;
            end
        end else if (!rst && mem_pending) begin
            check(`XLEN'(ex_ready_o), 0, "ex_ready_o during memory op");
        end
    end

    initial begin
        repeat (200 * total_ops + 100) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", 200 * total_ops + 100);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int err_before;
        seed        = 80;
        rst         = 1'b1;
        ex_valid_i  = 1'b0;
        ex_bundle_i = '0;
        mem_pending = 1'b0;
        for (int i = 0; i < mem_words; i++) ref_mem[i] = fill_word(i);
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        check_reset_state();
        run_test("nonmem", 0, 40);
        run_test("store", 1, 30);
        run_test("load", 2, 30);
        run_test("suppressed", 3, 20);
        run_test("backpressure", 4, 40);
        err_before = errors;
        check(retired, issued, "writeback count against issue count");
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        check_reset_state();
        $display("test reset: %0d errors", errors - err_before);
        $display("summary: 6 tests, %0d issued, %0d written back, %0d errors",
                 issued, retired, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tb/mem_wb_sva.sv
`timescale 1ns/1ps
`include "rv32_wb_config.svh"

module mem_wb_sva
    import mem_access_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   ex_ready_o,
    input logic                   mem_req_o,
    input logic                   mem_ack_i,
    input mem_req_t               mem_cmd_o,
    input logic                   wb_valid_o,
    input logic                   wb_we_o,
    input logic [`REG_ADDR_W-1:0] wb_rd_o
);

    // four-phase, a new request waits for ack low.
    req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req_o) |-> !mem_ack_i)
        else $error("mem_req_o rose while mem_ack_i was high");

    cmd_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && $past(mem_req_o) |-> $stable(mem_cmd_o))
        else $error("mem_cmd_o changed while mem_req_o was high");

    busy_blocks_upstream: assert property (@(posedge clk) disable iff (rst)
        mem_req_o |-> !ex_ready_o)
        else $error("ex_ready_o high during a memory request");

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        (wb_rd_o == '0) |-> !wb_we_o)
        else $error("write enable raised for x0");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !wb_valid_o && !wb_we_o)
        else $error("writeback active in the cycle after reset");

endmodule

//--- hw/mem_wb_top.sv
`timescale 1ns/1ps
`include "rv32_wb_config.svh"

module mem_wb_top
    import rv32i_types_pkg::*;
    import mem_access_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ex_valid_i,
    input  ex_mem_t                ex_bundle_i,
    input  logic                   mem_ack_i,
    input  logic [`XLEN-1:0]       mem_rdata_i,
    output logic                   ex_ready_o,
    output logic                   mem_req_o,
    output mem_req_t               mem_cmd_o,
    output logic                   wb_valid_o,
    output logic                   wb_we_o,
    output logic [`REG_ADDR_W-1:0] wb_rd_o,
    output logic [`XLEN-1:0]       wb_data_o
);

    logic                   is_mem_op;
    logic                   ex_accept;
    logic                   mem_start;
    logic                   mem_busy;
    logic                   mem_done;
    logic                   wb_load;
    logic                   stage_valid;
    logic [`XLEN-1:0]       nonmem_result;
    logic [`XLEN-1:0]       load_data;
    rv32i_control_word      pend_ctrl_q;
    logic [`REG_ADDR_W-1:0] pend_rd_q;
    logic [`XLEN-1:0]       pend_result_q;
    mem_wb_t                stage_d;
    mem_wb_t                stage_q;

    assign is_mem_op  = ex_bundle_i.ctrl.mem_read | ex_bundle_i.ctrl.mem_write;
    assign ex_ready_o = ~mem_busy;
    assign ex_accept  = ex_valid_i & ex_ready_o;
    assign mem_start  = ex_accept & is_mem_op;
    assign wb_load    = (ex_accept & ~is_mem_op) | mem_done;

    // upstream moves on after accept, so keep the memory op's fields.
    always_ff @(posedge clk) begin
        if (mem_start) begin
            pend_ctrl_q   <= ex_bundle_i.ctrl;
            pend_rd_q     <= ex_bundle_i.rd;
            pend_result_q <= nonmem_result;
        end
    end

    always_comb begin
        stage_d.load_data = load_data;
        if (mem_done) begin
            stage_d.ctrl   = pend_ctrl_q;
            stage_d.rd     = pend_rd_q;
            stage_d.result = pend_result_q;
        end else begin
            stage_d.ctrl   = ex_bundle_i.ctrl;
            stage_d.rd     = ex_bundle_i.rd;
            stage_d.result = nonmem_result;
        end
    end

    load_unit i_load_unit (
        .clk         (clk),
        .rst         (rst),
        .start_i     (mem_start),
        .bundle_i    (ex_bundle_i),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .busy_o      (mem_busy),
        .mem_req_o   (mem_req_o),
        .mem_cmd_o   (mem_cmd_o),
        .done_o      (mem_done),
        .load_data_o (load_data)
    );

    result_select i_result_select (
        .bundle_i (ex_bundle_i),
        .result_o (nonmem_result)
    );

    mem_wb i_mem_wb (
        .clk     (clk),
        .rst     (rst),
        .load_i  (wb_load),
        .data_i  (stage_d),
        .data_o  (stage_q),
        .valid_o (stage_valid)
    );

    writeback_unit i_writeback_unit (
        .stage_i    (stage_q),
        .valid_i    (stage_valid),
        .wb_valid_o (wb_valid_o),
        .wb_we_o    (wb_we_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

//--- hw/writeback_unit.sv
`timescale 1ns/1ps
`include "rv32_wb_config.svh"

module writeback_unit
    import rv32i_types_pkg::*;
(
    input  mem_wb_t                stage_i,
    input  logic                   valid_i,
    output logic                   wb_valid_o,
    output logic                   wb_we_o,
    output logic [`REG_ADDR_W-1:0] wb_rd_o,
    output logic [`XLEN-1:0]       wb_data_o
);

    logic rd_nonzero;

    assign rd_nonzero = |stage_i.rd;

    // x0 stays zero.
    assign wb_valid_o = valid_i;
    assign wb_we_o    = valid_i & stage_i.ctrl.reg_write & rd_nonzero;
    assign wb_rd_o    = stage_i.rd;

    always_comb begin
        if (stage_i.ctrl.wb_sel == wb_mem) begin
            wb_data_o = stage_i.load_data;
        end else begin
            wb_data_o = stage_i.result;
        end
    end

endmodule

//--- hw/mem_wb.sv
`timescale 1ns/1ps
`include "rv32_wb_config.svh"

module mem_wb
    import rv32i_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    load_i,
    input  mem_wb_t data_i,
    output mem_wb_t data_o,
    output logic    valid_o
);

    mem_wb_t stage_q;
    logic    valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_i; // one pulse per captured op.
            if (load_i) begin
                stage_q <= data_i;
            end
        end
    end

    assign data_o  = stage_q;
    assign valid_o = valid_q;

endmodule

//--- hw/result_select.sv
`timescale 1ns/1ps
`include "rv32_wb_config.svh"

module result_select
    import rv32i_types_pkg::*;
(
    input  ex_mem_t          bundle_i,
    output logic [`XLEN-1:0] result_o
);

    always_comb begin
        case (bundle_i.ctrl.wb_sel)
            wb_alu:  result_o = bundle_i.alu_out;
            wb_pc4:  result_o = bundle_i.pc_plus4;
            wb_uimm: result_o = bundle_i.u_imm;
            wb_br:   result_o = {{(`XLEN-1){1'b0}}, bundle_i.br_en}; // slt style.
            default: result_o = '0; // loads come from load_unit.
        endcase
    end

endmodule

//--- hw/load_unit.sv
`timescale 1ns/1ps
`include "rv32_wb_config.svh"

module load_unit
    import rv32i_types_pkg::*;
    import mem_access_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start_i,
    input  ex_mem_t          bundle_i,
    input  logic             mem_ack_i,
    input  logic [`XLEN-1:0] mem_rdata_i,
    output logic             busy_o,
    output logic             mem_req_o,
    output mem_req_t         mem_cmd_o,
    output logic             done_o,
    output logic [`XLEN-1:0] load_data_o
);

    hs_state_e        state_q;
    mem_req_t         cmd_q;
    mem_width_e       width_q;
    logic [1:0]       offset_q;

    mem_width_e       width_d;
    logic [1:0]       offset_d;
    logic [3:0]       mask_d;
    logic [`XLEN-1:0] wdata_d;
    logic [`XLEN-1:0] lane_data;
    logic [`XLEN-1:0] ext_data;

    // store side, decoded from the incoming bundle.
    always_comb begin
        width_d  = mem_width_e'(bundle_i.ctrl.funct3);
        offset_d = (width_d == mw_word) ? 2'b00 : bundle_i.alu_out[1:0];
        case (width_d)
            mw_byte: mask_d = 4'b0001 << offset_d;
            mw_half: mask_d = 4'b0011 << offset_d;
            default: mask_d = 4'b1111;
        endcase
        wdata_d = bundle_i.store_data << {offset_d, 3'b000};
    end

    // load side, addressed lane moved down then extended.
    always_comb begin
        lane_data = mem_rdata_i >> {offset_q, 3'b000};
        case (width_q)
            mw_byte:   ext_data = {{(`XLEN-8){lane_data[7]}}, lane_data[7:0]};
            mw_half:   ext_data = {{(`XLEN-16){lane_data[15]}}, lane_data[15:0]};
            mw_byte_u: ext_data = {{(`XLEN-8){1'b0}}, lane_data[7:0]};
            mw_half_u: ext_data = {{(`XLEN-16){1'b0}}, lane_data[15:0]};
            default:   ext_data = lane_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= hs_idle;
        end else begin
            case (state_q)
                hs_idle: begin
                    if (start_i) begin
                        state_q <= hs_req;
                    end
                end
                hs_req: begin
                    if (mem_ack_i) begin
                        state_q <= hs_release;
                    end
                end
                hs_release: begin
                    if (!mem_ack_i) begin
                        state_q <= hs_done; // ack seen low.
                    end
                end
                default: state_q <= hs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == hs_idle && start_i) begin
            cmd_q.addr  <= bundle_i.alu_out[`XLEN-1:2];
            cmd_q.write <= bundle_i.ctrl.mem_write;
            cmd_q.mask  <= bundle_i.ctrl.mem_write ? mask_d : 4'b1111;
            cmd_q.wdata <= wdata_d;
            width_q     <= width_d;
            offset_q    <= offset_d;
        end
        if (state_q == hs_req && mem_ack_i) begin
            load_data_o <= ext_data; // rdata valid with ack.
        end
    end

    assign busy_o    = (state_q != hs_idle);
    assign mem_req_o = (state_q == hs_req);
    assign done_o    = (state_q == hs_done);
    assign mem_cmd_o = cmd_q;

endmodule

//--- hw/mem_access_pkg.sv
`include "rv32_wb_config.svh"

package mem_access_pkg;

    // access width, encoded as funct3.
    typedef enum logic [2:0] {
        mw_byte   = 3'b000,
        mw_half   = 3'b001,
        mw_word   = 3'b010,
        mw_byte_u = 3'b100,
        mw_half_u = 3'b101
    } mem_width_e;

    // four-phase handshake states.
    typedef enum logic [1:0] {
        hs_idle    = 2'd0,
        hs_req     = 2'd1,
        hs_release = 2'd2,
        hs_done    = 2'd3
    } hs_state_e;

    typedef struct packed {
        logic [`XLEN-3:0] addr;  // word address.
        logic             write;
        logic [3:0]       mask;
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

endpackage

//--- hw/rv32i_types_pkg.sv
`include "rv32_wb_config.svh"

package rv32i_types_pkg;

    // RV32I major opcodes.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    // writeback source.
    typedef enum logic [2:0] {
        wb_alu  = 3'd0,
        wb_mem  = 3'd1,
        wb_pc4  = 3'd2,
        wb_uimm = 3'd3,
        wb_br   = 3'd4
    } wb_sel_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        wb_sel_e    wb_sel;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
    } rv32i_control_word;

    // bundle from the execute stage.
    typedef struct packed {
        rv32i_control_word      ctrl;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       pc_plus4;
        logic [`XLEN-1:0]       alu_out;
        logic [`XLEN-1:0]       u_imm;
        logic                   br_en;
        logic [`XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        rv32i_control_word      ctrl;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;    // non-memory result.
        logic [`XLEN-1:0]       load_data; // aligned, extended.
    } mem_wb_t;

endpackage

//--- hw/rv32_wb_config.svh
`ifndef RV32_WB_CONFIG_SVH
`define RV32_WB_CONFIG_SVH

// datapath width.
`define XLEN 32

// register index width.
`define REG_ADDR_W 5

// word address bits modelled by the data memory.
`define MEM_ADDR_W 8

`endif
